/* hw/tile_dec_pkg.sv */
/*
 * Pixel, coefficient, residual and row types
 * Block constants for the lossless 4x4 tile decoder
 */
package tile_dec_pkg;

    // ==========================================================
    // Block geometry and pixel range
    // ==========================================================
    localparam int BLK     = 4;
    localparam int PIX_W   = 10;
    localparam int PIX_MAX = 1023;
    // Stand-in for a neighbour outside the tile
    localparam int PIX_MID = 512;

    // ==========================================================
    // Scalar and row types
    // ==========================================================
    typedef logic [PIX_W-1:0]   pixel_t;
    typedef logic signed [15:0] coef_t;
    typedef logic signed [17:0] resid_t;

    // Element 0 is the leftmost sample, at the lowest address
    typedef coef_t  [BLK-1:0] coef_row_t;
    typedef resid_t [BLK-1:0] resid_row_t;
    typedef pixel_t [BLK-1:0] pix_row_t;

    // Prediction row tagged with its place in the tile
    typedef struct packed {
        pix_row_t    pix;
        logic [15:0] blk_col;
        logic [15:0] pix_row;
    } pred_row_t;

endpackage

/* hw/row_fifo.sv */
/*
 * Small valid/ready FIFO with a type-parameterized payload
 */
`timescale 1ns/1ps

module row_fifo #(
    parameter type payload_t  = logic,
    parameter int  FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    // Pointer wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_ready  = (count != (PTR_W + 1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* hw/inv_wht4x4.sv */
/*
 * Inverse 4x4 Walsh-Hadamard transform
 * Row gather buffer, row and column passes, double-buffered output
 */
`timescale 1ns/1ps

module inv_wht4x4 (
    input  logic                     clk,
    input  logic                     rst_n,
    input  tile_dec_pkg::coef_row_t  coef_data,
    input  logic                     coef_valid,
    output logic                     coef_ready,
    output tile_dec_pkg::resid_row_t res_row,
    output logic                     res_valid,
    input  logic                     res_ready
);
    import tile_dec_pkg::*;

    // Two passes grow a 16-bit input by four bits
    typedef logic signed [19:0] acc_t;
    typedef acc_t [BLK-1:0]     acc_row_t;

    coef_row_t  in_buf   [BLK];
    resid_row_t out_buf  [BLK];
    acc_row_t   row_pass [BLK];
    resid_row_t tx_rows  [BLK];

    logic [1:0] in_cnt;
    logic [1:0] out_idx;
    logic       in_full;
    logic       out_full;
    logic       in_fire;
    logic       move;
    logic       out_of_reset;

    // 4-point Hadamard butterfly
    function automatic acc_row_t wht4(acc_row_t a);
        acc_row_t o;
        o[0] = a[0] + a[1] + a[2] + a[3];
        o[1] = a[0] + a[1] - a[2] - a[3];
        o[2] = a[0] - a[1] - a[2] + a[3];
        o[3] = a[0] - a[1] + a[2] - a[3];
        return o;
    endfunction

    // ==========================================================
    // Transform of the gathered block
    // ==========================================================
    always_comb begin : tx_comb
        acc_row_t a;
        acc_row_t col;
        acc_t     v;
        for (int r = 0; r < BLK; r++) begin
            for (int c = 0; c < BLK; c++) begin
                a[c] = in_buf[r][c];
            end
            row_pass[r] = wht4(a);
        end
        for (int c = 0; c < BLK; c++) begin
            for (int r = 0; r < BLK; r++) begin
                a[r] = row_pass[r][c];
            end
            col = wht4(a);
            for (int r = 0; r < BLK; r++) begin
                v             = col[r] >>> 2;
                tx_rows[r][c] = resid_t'(v);
            end
        end
    end

    // ==========================================================
    // Handshake and buffer control
    // ==========================================================
    // Stall only when both buffers hold a block, and low in reset
    assign coef_ready = out_of_reset && !(in_full && out_full);
    assign in_fire    = coef_valid && coef_ready;
    assign move       = in_full && !out_full;
    assign res_valid  = out_full;
    assign res_row    = out_buf[out_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_of_reset <= 1'b0;
            in_cnt       <= '0;
            in_full      <= 1'b0;
            out_idx      <= '0;
            out_full     <= 1'b0;
        end else begin
            out_of_reset <= 1'b1;
            if (move) begin
                in_full <= 1'b0;
            end
            // A row taken during a move lands in slot 0
            if (in_fire) begin
                in_cnt <= in_cnt + 2'd1;
                if (in_cnt == 2'd3) begin
                    in_full <= 1'b1;
                end
            end
            if (move) begin
                out_full <= 1'b1;
                out_idx  <= '0;
            end else if (out_full && res_ready) begin
                out_idx <= out_idx + 2'd1;
                if (out_idx == 2'd3) begin
                    out_full <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            in_buf[in_cnt] <= coef_data;
        end
        if (move) begin
            out_buf <= tx_rows;
        end
    end

endmodule

/* hw/block_scan_ctrl.sv */
/*
 * Tile controller: raster walk over 4x4 blocks
 * Issues one prediction request per block and flags tile completion
 */
`timescale 1ns/1ps

module block_scan_ctrl #(
    parameter int MAX_WIDTH  = 128,
    parameter int MAX_HEIGHT = 128
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [15:0] frame_width,
    input  logic [15:0] frame_height,
    input  logic        blk_done,
    output logic        pred_start,
    output logic [15:0] blk_x,
    output logic [15:0] blk_y,
    output logic        tile_busy,
    output logic        tile_done
);
    import tile_dec_pkg::*;

    // Enough room for every block of the largest tile
    localparam int MAX_BLOCKS = (MAX_WIDTH / BLK) * (MAX_HEIGHT / BLK);
    localparam int CNT_W      = $clog2(MAX_BLOCKS + 1);

    logic [15:0]      blocks_x;
    logic [15:0]      blocks_y;
    logic [31:0]      total_blocks;
    logic [CNT_W-1:0] done_cnt;
    logic             last_blk;

    assign total_blocks = blocks_x * blocks_y;
    assign last_blk     = (32'(done_cnt) + 32'd1 == total_blocks);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blocks_x   <= '0;
            blocks_y   <= '0;
            blk_x      <= '0;
            blk_y      <= '0;
            done_cnt   <= '0;
            pred_start <= 1'b0;
            tile_busy  <= 1'b0;
            tile_done  <= 1'b0;
        end else begin
            pred_start <= 1'b0;
            tile_done  <= 1'b0;
            if (start && !tile_busy) begin
                // Partial blocks at the edge count as whole ones
                blocks_x   <= 16'((17'(frame_width) + 17'(BLK - 1)) / 17'(BLK));
                blocks_y   <= 16'((17'(frame_height) + 17'(BLK - 1)) / 17'(BLK));
                blk_x      <= '0;
                blk_y      <= '0;
                done_cnt   <= '0;
                tile_busy  <= 1'b1;
                pred_start <= 1'b1;
            end else if (tile_busy && blk_done) begin
                if (last_blk) begin
                    tile_busy <= 1'b0;
                    tile_done <= 1'b1;
                end else begin
                    done_cnt   <= done_cnt + 1'b1;
                    pred_start <= 1'b1;
                    // Raster order, wrap to the next block row
                    if (blk_x == blocks_x - 16'd1) begin
                        blk_x <= '0;
                        blk_y <= blk_y + 16'd1;
                    end else begin
                        blk_x <= blk_x + 16'd1;
                    end
                end
            end
        end
    end

endmodule

/* hw/dc_intra_pred.sv */
/*
 * DC intra predictor for 4x4 blocks
 * Top line and left column buffers fed from reconstructed rows
 */
`timescale 1ns/1ps

module dc_intra_pred #(
    parameter int MAX_WIDTH = 128
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pred_start,
    input  logic [15:0]             blk_x,
    input  logic [15:0]             blk_y,
    input  logic                    tile_busy,
    input  logic                    fb_valid,
    input  tile_dec_pkg::pix_row_t  fb_row,
    input  logic [15:0]             fb_x,
    input  logic [15:0]             fb_y,
    output tile_dec_pkg::pred_row_t pred_row,
    output logic                    pred_valid,
    input  logic                    pred_ready
);
    import tile_dec_pkg::*;

    localparam int COLS  = MAX_WIDTH / BLK;
    localparam int IDX_W = $clog2(COLS);

    // Bottom row of the latest block in each block column
    pix_row_t    top_line [COLS];
    // Rightmost pixel of each row of the previous block
    pix_row_t    left_col;

    logic [15:0] cur_x;
    logic [15:0] cur_y;
    logic        has_top;
    logic        has_left;
    logic        calc;
    logic        emit;
    logic [1:0]  row_idx;
    logic [11:0] sum_top;
    logic [11:0] sum_left;
    pixel_t      dc_next;
    pixel_t      dc;

    // ==========================================================
    // Neighbour buffers
    // ==========================================================
    always_ff @(posedge clk) begin
        if (!tile_busy) begin
            for (int i = 0; i < COLS; i++) begin
                top_line[i] <= {BLK{pixel_t'(PIX_MID)}};
            end
            left_col <= {BLK{pixel_t'(PIX_MID)}};
        end else if (fb_valid) begin
            if (fb_y[1:0] == 2'd3) begin
                top_line[fb_x[IDX_W-1:0]] <= fb_row;
            end
            left_col[fb_y[1:0]] <= fb_row[BLK-1];
        end
    end

    // ==========================================================
    // DC value
    // ==========================================================
    always_comb begin
        sum_top  = '0;
        sum_left = '0;
        for (int c = 0; c < BLK; c++) begin
            sum_top  = sum_top + 12'(top_line[cur_x[IDX_W-1:0]][c]);
            sum_left = sum_left + 12'(left_col[c]);
        end
        if (has_top && has_left) begin
            dc_next = pixel_t'((13'(sum_top) + 13'(sum_left) + 13'd4) >> 3);
        end else if (has_top) begin
            dc_next = pixel_t'((sum_top + 12'd2) >> 2);
        end else if (has_left) begin
            dc_next = pixel_t'((sum_left + 12'd2) >> 2);
        end else begin
            dc_next = pixel_t'(PIX_MID);
        end
    end

    // Request latched, DC computed next cycle, then four rows out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            calc    <= 1'b0;
            emit    <= 1'b0;
            row_idx <= '0;
        end else begin
            calc <= pred_start;
            if (calc) begin
                emit    <= 1'b1;
                row_idx <= '0;
            end else if (emit && pred_ready) begin
                row_idx <= row_idx + 2'd1;
                if (row_idx == 2'd3) begin
                    emit <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pred_start) begin
            cur_x    <= blk_x;
            cur_y    <= blk_y;
            has_top  <= (blk_y != 16'd0);
            has_left <= (blk_x != 16'd0);
        end
        if (calc) begin
            dc <= dc_next;
        end
    end

    assign pred_valid = emit;

    always_comb begin
        pred_row.pix     = {BLK{dc}};
        pred_row.blk_col = cur_x;
        pred_row.pix_row = {cur_y[13:0], row_idx};
    end

endmodule

/* hw/recon_merge.sv */
/*
 * Reconstruction: residual plus prediction, clipped to the pixel range
 * Row write-out with address, feedback to the predictor, block done
 */
`timescale 1ns/1ps

module recon_merge #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [15:0]              frame_width,
    input  tile_dec_pkg::resid_row_t res_row,
    input  logic                     res_valid,
    output logic                     res_ready,
    input  tile_dec_pkg::pred_row_t  pred_row,
    input  logic                     pred_valid,
    output logic                     pred_ready,
    output tile_dec_pkg::pix_row_t   recon_data,
    output logic [31:0]              recon_addr,
    output logic                     recon_wr_en,
    output logic                     fb_valid,
    output tile_dec_pkg::pix_row_t   fb_row,
    output logic [15:0]              fb_x,
    output logic [15:0]              fb_y,
    output logic                     blk_done
);
    import tile_dec_pkg::*;

    resid_row_t        res_q;
    logic              res_q_valid;
    pred_row_t         pred_q;
    logic              pred_q_valid;
    logic              pop;
    logic [1:0]        row_cnt;
    pix_row_t          sum_row;
    logic [31:0]       addr_next;
    logic signed [19:0] rv;
    logic signed [19:0] pv;
    logic signed [19:0] sum;

    row_fifo #(
        .payload_t  (resid_row_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_res_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (res_row),
        .in_valid  (res_valid),
        .in_ready  (res_ready),
        .out_data  (res_q),
        .out_valid (res_q_valid),
        .out_ready (pop)
    );

    row_fifo #(
        .payload_t  (pred_row_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_pred_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (pred_row),
        .in_valid  (pred_valid),
        .in_ready  (pred_ready),
        .out_data  (pred_q),
        .out_valid (pred_q_valid),
        .out_ready (pop)
    );

    // Rows pair up in order, so both heads belong together
    assign pop = res_q_valid && pred_q_valid;

    always_comb begin
        for (int c = 0; c < BLK; c++) begin
            rv  = res_q[c];
            pv  = {10'd0, pred_q.pix[c]};
            sum = rv + pv;
            if (sum < 0) begin
                sum_row[c] = '0;
            end else if (sum > PIX_MAX) begin
                sum_row[c] = pixel_t'(PIX_MAX);
            end else begin
                sum_row[c] = sum[PIX_W-1:0];
            end
        end
        addr_next = 32'(pred_q.pix_row) * 32'(frame_width)
                  + 32'(pred_q.blk_col) * BLK;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            recon_wr_en <= 1'b0;
            blk_done    <= 1'b0;
            row_cnt     <= '0;
        end else begin
            recon_wr_en <= pop;
            blk_done    <= pop && (row_cnt == 2'd3);
            if (pop) begin
                row_cnt <= row_cnt + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            recon_data <= sum_row;
            recon_addr <= addr_next;
            fb_x       <= pred_q.blk_col;
            fb_y       <= pred_q.pix_row;
        end
    end

    // Feedback carries the same registered row as the write port
    assign fb_valid = recon_wr_en;
    assign fb_row   = recon_data;

endmodule

/* hw/tile_decoder.sv */
/*
 * Lossless tile decoder top level
 * Block scan control, inverse WHT, DC prediction and reconstruction
 */
`timescale 1ns/1ps

module tile_decoder #(
    parameter int MAX_WIDTH  = 128,
    parameter int MAX_HEIGHT = 128,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [15:0]             frame_width,
    input  logic [15:0]             frame_height,
    input  tile_dec_pkg::coef_row_t coef_data,
    input  logic                    coef_valid,
    output logic                    coef_ready,
    output tile_dec_pkg::pix_row_t  recon_data,
    output logic [31:0]             recon_addr,
    output logic                    recon_wr_en,
    output logic                    tile_done
);
    import tile_dec_pkg::*;

    // Controller side
    logic        pred_start;
    logic [15:0] blk_x;
    logic [15:0] blk_y;
    logic        tile_busy;
    logic        blk_done;

    // Row streams into the merge stage
    resid_row_t  res_row;
    logic        res_valid;
    logic        res_ready;
    pred_row_t   pred_row;
    logic        pred_valid;
    logic        pred_ready;

    // Reconstructed rows back to the predictor
    logic        fb_valid;
    pix_row_t    fb_row;
    logic [15:0] fb_x;
    logic [15:0] fb_y;

    block_scan_ctrl #(
        .MAX_WIDTH  (MAX_WIDTH),
        .MAX_HEIGHT (MAX_HEIGHT)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .frame_width  (frame_width),
        .frame_height (frame_height),
        .blk_done     (blk_done),
        .pred_start   (pred_start),
        .blk_x        (blk_x),
        .blk_y        (blk_y),
        .tile_busy    (tile_busy),
        .tile_done    (tile_done)
    );

    inv_wht4x4 u_wht (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef_data  (coef_data),
        .coef_valid (coef_valid),
        .coef_ready (coef_ready),
        .res_row    (res_row),
        .res_valid  (res_valid),
        .res_ready  (res_ready)
    );

    dc_intra_pred #(
        .MAX_WIDTH (MAX_WIDTH)
    ) u_pred (
        .clk        (clk),
        .rst_n      (rst_n),
        .pred_start (pred_start),
        .blk_x      (blk_x),
        .blk_y      (blk_y),
        .tile_busy  (tile_busy),
        .fb_valid   (fb_valid),
        .fb_row     (fb_row),
        .fb_x       (fb_x),
        .fb_y       (fb_y),
        .pred_row   (pred_row),
        .pred_valid (pred_valid),
        .pred_ready (pred_ready)
    );

    recon_merge #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_merge (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_width (frame_width),
        .res_row     (res_row),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .pred_row    (pred_row),
        .pred_valid  (pred_valid),
        .pred_ready  (pred_ready),
        .recon_data  (recon_data),
        .recon_addr  (recon_addr),
        .recon_wr_en (recon_wr_en),
        .fb_valid    (fb_valid),
        .fb_row      (fb_row),
        .fb_x        (fb_x),
        .fb_y        (fb_y),
        .blk_done    (blk_done)
    );

endmodule

/* verif/tb_ref_model.svh */
/*
 * Reference model of the tile decoder
 * Inverse 4x4 WHT, DC prediction and clipped reconstruction of a tile
 */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Output k of the 4-point Hadamard butterfly
function automatic int hadamard_out(int a0, int a1, int a2, int a3, int k);
    case (k)
        0:       return a0 + a1 + a2 + a3;
        1:       return a0 + a1 - a2 - a3;
        2:       return a0 - a1 - a2 + a3;
        default: return a0 - a1 + a2 - a3;
    endcase
endfunction

function automatic int clip_pixel(int v);
    if (v < 0) begin
        return 0;
    end
    if (v > 1023) begin
        return 1023;
    end
    return v;
endfunction

// DC from reconstructed neighbours, mid-grey with none
function automatic int dc_value(int bx, int by);
    int sum_top;
    int sum_left;
    sum_top  = 0;
    sum_left = 0;
    for (int i = 0; i < 4; i++) begin
        if (by > 0) begin
            sum_top = sum_top + exp_pix[4 * by - 1][4 * bx + i];
        end
        if (bx > 0) begin
            sum_left = sum_left + exp_pix[4 * by + i][4 * bx - 1];
        end
    end
    if (by > 0 && bx > 0) begin
        return (sum_top + sum_left + 4) / 8;
    end else if (by > 0) begin
        return (sum_top + 2) / 4;
    end else if (bx > 0) begin
        return (sum_left + 2) / 4;
    end
    return 512;
endfunction

// Whole tile, blocks in raster order
function automatic void build_expected();
    int bw;
    int blk;
    int dc;
    int t [4][4];
    int r [4][4];
    bw = tile_w / 4;
    for (int by = 0; by < tile_h / 4; by++) begin
        for (int bx = 0; bx < bw; bx++) begin
            blk = by * bw + bx;
            // Row pass
            for (int y = 0; y < 4; y++) begin
                for (int k = 0; k < 4; k++) begin
                    t[y][k] = hadamard_out(int'(coef_mem[blk * 4 + y][0]),
                                           int'(coef_mem[blk * 4 + y][1]),
                                           int'(coef_mem[blk * 4 + y][2]),
                                           int'(coef_mem[blk * 4 + y][3]), k);
                end
            end
            // Column pass and final scaling
            for (int x = 0; x < 4; x++) begin
                for (int k = 0; k < 4; k++) begin
                    r[k][x] = hadamard_out(t[0][x], t[1][x], t[2][x], t[3][x], k) >>> 2;
                end
            end
            dc = dc_value(bx, by);
            for (int y = 0; y < 4; y++) begin
                for (int x = 0; x < 4; x++) begin
                    exp_pix[4 * by + y][4 * bx + x] = clip_pixel(r[y][x] + dc);
                end
            end
        end
    end
endfunction

`endif

/* verif/tb_tile_decoder.sv */
/*
 * Testbench for the lossless tile decoder
 * Clock, reset, coefficient stimulus, write checker and scenarios
 */
`timescale 1ns/1ps

module tb_tile_decoder;
    import tile_dec_pkg::*;

    localparam int TB_MAX_W    = 32;
    localparam int TB_MAX_H    = 16;
    localparam int MAX_ROWS    = (TB_MAX_W / BLK) * TB_MAX_H;
    localparam int WAIT_LIMIT  = 2000;
    localparam int FILL_ZERO   = 0;
    localparam int FILL_RANDOM = 1;
    localparam int FILL_LARGE  = 2;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [15:0] frame_width;
    logic [15:0] frame_height;
    coef_row_t   coef_data;
    logic        coef_valid;
    logic        coef_ready;
    pix_row_t    recon_data;
    logic [31:0] recon_addr;
    logic        recon_wr_en;
    logic        tile_done;

    // Tile under test and its expected pixels
    int          tile_w;
    int          tile_h;
    coef_row_t   coef_mem [MAX_ROWS];
    int          exp_pix [TB_MAX_H][TB_MAX_W];
    int          wr_idx;
    int          exp_writes;
    int          done_cnt;
    int          tiles_run;
    int          checks;
    int          errors;

    `include "tb_ref_model.svh"

    tile_decoder #(
        .MAX_WIDTH  (128),
        .MAX_HEIGHT (128),
        .FIFO_DEPTH (4)
    ) dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .frame_width  (frame_width),
        .frame_height (frame_height),
        .coef_data    (coef_data),
        .coef_valid   (coef_valid),
        .coef_ready   (coef_ready),
        .recon_data   (recon_data),
        .recon_addr   (recon_addr),
        .recon_wr_en  (recon_wr_en),
        .tile_done    (tile_done)
    );

    always #5 clk = ~clk;

    // ==========================================================
    // Compare tasks and run end
    // ==========================================================
    task automatic report_mismatch(string msg);
        errors++;
        $display("Fail at %0t: %s", $time, msg);
    endtask

    task automatic check_row(string what, pix_row_t got, pix_row_t exp);
        checks++;
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
        end
    endtask

    task automatic check_addr(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic check_done(string what, int got, int exp);
        checks++;
        if (got != exp) begin
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(string what);
        errors++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    // ==========================================================
    // Write checker
    // ==========================================================
    always @(negedge clk) begin : compare_writes
        int       blk;
        int       bx;
        int       y;
        pix_row_t exp_row;
        if (rst_n && recon_wr_en) begin
            if (wr_idx >= exp_writes) begin
                errors++;
                $display("Write to address %0d came after the tile was complete", recon_addr);
            end else begin
                blk = wr_idx / BLK;
                bx  = blk % (tile_w / BLK);
                y   = (blk / (tile_w / BLK)) * BLK + wr_idx % BLK;
                for (int c = 0; c < BLK; c++) begin
                    exp_row[c] = pixel_t'(exp_pix[y][bx * BLK + c]);
                end
                check_addr("write address", recon_addr, 32'(y * tile_w + bx * BLK));
                check_row("reconstructed row", recon_data, exp_row);
            end
            wr_idx++;
        end
        if (rst_n && tile_done) begin
            done_cnt++;
            // All rows of the tile must precede the done pulse
            check_done("writes at tile_done", wr_idx, exp_writes);
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================
    task automatic fill_coefs(int mode);
        for (int i = 0; i < exp_writes; i++) begin
            for (int c = 0; c < BLK; c++) begin
                if (mode == FILL_RANDOM) begin
                    coef_mem[i][c] = coef_t'(int'($urandom_range(0, 255)) - 128);
                end else if (mode == FILL_LARGE && i % BLK == 0 && c == 0) begin
                    // Alternate extreme DC terms from block to block
                    coef_mem[i][c] = ((i / BLK) % 2 == 0) ? 16'sd32767 : -16'sd32768;
                end else begin
                    coef_mem[i][c] = '0;
                end
            end
        end
    endtask

    // Ready depends on DUT state only, so it is sampled at the falling edge
    task automatic send_row(coef_row_t row);
        int wait_cnt;
        coef_data  = row;
        coef_valid = 1'b1;
        wait_cnt   = 0;
        @(negedge clk);
        while (!coef_ready) begin
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                abort_on_timeout("coef_ready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic feed_tile(bit gaps);
        int n_gap;
        for (int i = 0; i < exp_writes; i++) begin
            if (gaps) begin
                n_gap = $urandom_range(0, 3);
                if (n_gap > 0) begin
                    coef_valid = 1'b0;
                    repeat (n_gap) @(posedge clk);
                    #1;
                end
            end
            send_row(coef_mem[i]);
        end
        coef_valid = 1'b0;
    endtask

    task automatic run_tile(int w, int h, int mode, bit gaps);
        int wait_cnt;
        int done_before;
        tile_w     = w;
        tile_h     = h;
        exp_writes = (w / BLK) * h;
        wr_idx     = 0;
        fill_coefs(mode);
        build_expected();
        done_before  = done_cnt;
        frame_width  = 16'(w);
        frame_height = 16'(h);
        start        = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        feed_tile(gaps);
        wait_cnt = 0;
        while (done_cnt == done_before) begin
            wait_cnt++;
            if (wait_cnt > WAIT_LIMIT) begin
                abort_on_timeout("tile_done");
            end
            @(posedge clk);
        end
        #1;
        tiles_run++;
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        frame_width  = '0;
        frame_height = '0;
        coef_data    = '0;
        coef_valid   = 1'b0;
        tile_w       = BLK;
        tile_h       = BLK;
        wr_idx       = 0;
        exp_writes   = 0;
        done_cnt     = 0;
        tiles_run    = 0;
        checks       = 0;
        errors       = 0;
        void'($urandom(32'h7ba8a0ea));
        repeat (4) @(posedge clk);
        #1;
        // Handshake and write outputs stay low in reset
        check_done("coef_ready in reset", int'(coef_ready), 0);
        check_done("recon_wr_en in reset", int'(recon_wr_en), 0);
        check_done("tile_done in reset", int'(tile_done), 0);
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // Flat mid-grey tile
        run_tile(16, 8, FILL_ZERO, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        // Single block, prediction without neighbours
        run_tile(4, 4, FILL_RANDOM, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        // All four neighbour cases of DC prediction
        run_tile(32, 16, FILL_RANDOM, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        // Clipping at both ends of the pixel range
        run_tile(8, 4, FILL_LARGE, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        // Two tiles back to back with input gaps
        run_tile(16, 8, FILL_RANDOM, 1'b1);
        run_tile(16, 8, FILL_RANDOM, 1'b1);

        repeat (20) @(posedge clk);
        check_done("tile_done pulses", done_cnt, tiles_run);
        finish_run();
    end

endmodule

/* filelist.f */
+incdir+verif
hw/tile_dec_pkg.sv
hw/row_fifo.sv
hw/inv_wht4x4.sv
hw/block_scan_ctrl.sv
hw/dc_intra_pred.sv
hw/recon_merge.sv
hw/tile_decoder.sv
verif/tb_tile_decoder.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tile decoder testbench with Verilator

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=sim_tb_tile_decoder

verilator --binary --timing -Wno-fatal --top-module tb_tile_decoder \
    -f filelist.f --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "Simulation FAILED, see $LOG"
    exit 1
fi

echo "Simulation PASSED"
exit 0
